// ==== source/hazard_macros.svh ====
`ifndef HAZARD_MACROS_SVH
`define HAZARD_MACROS_SVH

////////////////////////////////////////////////////////////
// Widths
////////////////////////////////////////////////////////////
`define INSTR_W 32
`define REG_W   5
`define TIME_W  2
`define FWD_W   2

// Instruction field positions
`define OP_MSB 31
`define OP_LSB 26
`define RS_MSB 25
`define RS_LSB 21
`define RT_MSB 20
`define RT_LSB 16
`define RD_MSB 15
`define RD_LSB 11
`define FN_MSB 5
`define FN_LSB 0

////////////////////////////////////////////////////////////
// Opcodes and funct codes
////////////////////////////////////////////////////////////
`define OP_ADDSUB_R 6'b000000
`define OP_ORI      6'b001101
`define OP_LUI      6'b001111
`define OP_LW       6'b100011
`define OP_SW       6'b101011
`define OP_BEQ      6'b000100
`define OP_J        6'b000010
`define OP_JAL      6'b000011

`define FN_ADD 6'b100000
`define FN_SUB 6'b100010
`define FN_JR  6'b001000

// Forwarding selects
`define FWD_NONE   2'd0
`define FWD_FROM_E 2'd1
`define FWD_FROM_M 2'd2

// Link register for jal
`define RA_REG 5'd31

// Bubble word
`define NOP_INSTR 32'h0000_0000

`endif

// ==== source/hazardPkg.sv ====
`include "hazard_macros.svh"

package hazardPkg;

    ////////////////////////////////////////////////////////////
    // Pipeline word and register types
    ////////////////////////////////////////////////////////////

    // Full instruction word as fetched
    typedef logic [`INSTR_W-1:0] instr_t;

    // Register number where zero means no register
    typedef logic [`REG_W-1:0] regNum_t;

    // Cycles until an operand is needed or a result exists
    typedef logic [`TIME_W-1:0] stageTime_t;

    ////////////////////////////////////////////////////////////
    // Forwarding
    ////////////////////////////////////////////////////////////

    // Operand source picked in decode
    typedef logic [`FWD_W-1:0] fwdSel_t;

endpackage

// ==== source/useDecoder.sv ====
`include "hazard_macros.svh"

module useDecoder import hazardPkg::*; (
    input  instr_t     instrD,
    output regNum_t    rsUse,
    output regNum_t    rtUse,
    output stageTime_t rsTuse,
    output stageTime_t rtTuse
);

    logic [5:0] opcode;
    logic [5:0] funct;
    regNum_t    rs;
    regNum_t    rt;

    // Field split of the decode-stage word
    assign opcode = instrD[`OP_MSB:`OP_LSB];
    assign funct  = instrD[`FN_MSB:`FN_LSB];
    assign rs     = instrD[`RS_MSB:`RS_LSB];
    assign rt     = instrD[`RT_MSB:`RT_LSB];

    ////////////////////////////////////////////////////////////
    // Source registers and Tuse
    ////////////////////////////////////////////////////////////
    always_comb begin
        // Nothing read unless the opcode says so
        rsUse  = '0;
        rtUse  = '0;
        rsTuse = 2'd0;
        rtTuse = 2'd0;

        case (opcode)
            `OP_ADDSUB_R: begin
                if (funct == `FN_ADD || funct == `FN_SUB) begin
                    rsUse  = rs;
                    rtUse  = rt;
                    rsTuse = 2'd1;
                    rtTuse = 2'd1;
                end else if (funct == `FN_JR) begin
                    // Jump target needed right in decode
                    rsUse  = rs;
                    rsTuse = 2'd0;
                end
            end
            `OP_ORI,
            `OP_LW: begin
                rsUse  = rs;
                rsTuse = 2'd1;
            end
            `OP_SW: begin
                // Store data is only needed in the memory stage
                rsUse  = rs;
                rtUse  = rt;
                rsTuse = 2'd1;
                rtTuse = 2'd2;
            end
            `OP_BEQ: begin
                // Compared in decode
                rsUse  = rs;
                rtUse  = rt;
                rsTuse = 2'd0;
                rtTuse = 2'd0;
            end
            `OP_LUI,
            `OP_J,
            `OP_JAL: begin
                // No register operands
                rsUse = '0;
                rtUse = '0;
            end
            default: begin
                rsUse = '0;
                rtUse = '0;
            end
        endcase
    end

endmodule

// ==== source/writeDecoder.sv ====
`include "hazard_macros.svh"

module writeDecoder import hazardPkg::*; (
    input  instr_t     instrE,
    output regNum_t    destE,
    output stageTime_t tnewE
);

    logic [5:0] opcode;
    logic [5:0] funct;
    regNum_t    rt;
    regNum_t    rd;

    assign opcode = instrE[`OP_MSB:`OP_LSB];
    assign funct  = instrE[`FN_MSB:`FN_LSB];
    assign rt     = instrE[`RT_MSB:`RT_LSB];
    assign rd     = instrE[`RD_MSB:`RD_LSB];

    ////////////////////////////////////////////////////////////
    // Destination and Tnew of the execute-stage instruction
    ////////////////////////////////////////////////////////////
    always_comb begin
        // Destination zero stands for no write
        destE = '0;
        tnewE = 2'd0;

        case (opcode)
            `OP_ADDSUB_R: begin
                if (funct == `FN_ADD || funct == `FN_SUB) begin
                    destE = rd;
                    tnewE = 2'd1;
                end
            end
            `OP_LW: begin
                // Data arrives after the memory stage
                destE = rt;
                tnewE = 2'd2;
            end
            `OP_ORI,
            `OP_LUI: begin
                destE = rt;
                tnewE = 2'd1;
            end
            `OP_JAL: begin
                // Return address is known already in E
                destE = `RA_REG;
                tnewE = 2'd0;
            end
            default: begin
                destE = '0;
                tnewE = 2'd0;
            end
        endcase
    end

endmodule

// ==== source/stageTracker.sv ====
`include "hazard_macros.svh"

module stageTracker import hazardPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  instr_t     instrD,
    input  logic       stall,
    input  regNum_t    destE,
    input  stageTime_t tnewE,
    output instr_t     instrE,
    output regNum_t    destM,
    output stageTime_t tnewM
);

    stageTime_t tnewAged;

    ////////////////////////////////////////////////////////////
    // ID/EX instruction register
    ////////////////////////////////////////////////////////////

    // A stalled decode instruction stays in D while E gets a bubble
    always_ff @(posedge clk) begin
        if (!rstN) begin
            instrE <= `NOP_INSTR;
        end else if (stall) begin
            instrE <= `NOP_INSTR;
        end else begin
            instrE <= instrD;
        end
    end

    ////////////////////////////////////////////////////////////
    // EX/MEM write record
    ////////////////////////////////////////////////////////////

    // One stage closer to the result, floor at zero
    always_comb begin
        if (tnewE == 2'd0) begin
            tnewAged = 2'd0;
        end else begin
            tnewAged = tnewE - 2'd1;
        end
    end

    // M keeps moving during a stall
    always_ff @(posedge clk) begin
        if (!rstN) begin
            destM <= '0;
            tnewM <= 2'd0;
        end else begin
            destM <= destE;
            tnewM <= tnewAged;
        end
    end

    // Largest Tnew out of E is two, so M can see at most one
    tnewMBounded: assert property (
        @(posedge clk) disable iff (!rstN)
        tnewM <= 2'd1
    ) else $error("tnewM exceeds one");

endmodule

// ==== source/stallControl.sv ====
`include "hazard_macros.svh"

module stallControl import hazardPkg::*; (
    input  regNum_t    rsUse,
    input  regNum_t    rtUse,
    input  stageTime_t rsTuse,
    input  stageTime_t rtTuse,
    input  regNum_t    destE,
    input  stageTime_t tnewE,
    input  regNum_t    destM,
    input  stageTime_t tnewM,
    input  logic       clk,
    output logic       stall,
    output fwdSel_t    fwdRsSel,
    output fwdSel_t    fwdRtSel
);

    logic rsStallE;
    logic rsStallM;
    logic rtStallE;
    logic rtStallM;

    ////////////////////////////////////////////////////////////
    // Compare helpers
    ////////////////////////////////////////////////////////////

    // Result will not exist by the time the operand is needed
    function automatic logic lateResult(
        input regNum_t    src,
        input stageTime_t tuse,
        input regNum_t    dest,
        input stageTime_t tnew
    );
        return (src != '0) && (src == dest) && (tuse < tnew);
    endfunction

    // E is younger, so its value wins over M
    function automatic fwdSel_t pickFwd(
        input regNum_t    src,
        input regNum_t    dstE,
        input stageTime_t tnwE,
        input regNum_t    dstM,
        input stageTime_t tnwM
    );
        fwdSel_t sel;
        sel = `FWD_NONE;
        if (src != '0 && src == dstE && tnwE == 2'd0) begin
            sel = `FWD_FROM_E;
        end else if (src != '0 && src == dstM && tnwM == 2'd0) begin
            sel = `FWD_FROM_M;
        end
        return sel;
    endfunction

    ////////////////////////////////////////////////////////////
    // Stall and forwarding
    ////////////////////////////////////////////////////////////
    assign rsStallE = lateResult(rsUse, rsTuse, destE, tnewE);
    assign rsStallM = lateResult(rsUse, rsTuse, destM, tnewM);
    assign rtStallE = lateResult(rtUse, rtTuse, destE, tnewE);
    assign rtStallM = lateResult(rtUse, rtTuse, destM, tnewM);

    assign stall = rsStallE | rsStallM | rtStallE | rtStallM;

    assign fwdRsSel = pickFwd(rsUse, destE, tnewE, destM, tnewM);
    assign fwdRtSel = pickFwd(rtUse, destE, tnewE, destM, tnewM);

    // A stall puts a bubble into E, so E cannot cause the next one
    stallClearsE: assert property (
        @(posedge clk) stall |=> !(rsStallE || rtStallE)
    ) else $error("stall against E right after a bubble");

    // A load-use conflict resolves within two stall cycles
    stallAtMostTwo: assert property (
        @(posedge clk) (stall && $past(stall)) |=> !stall
    ) else $error("stall held for more than two cycles");

endmodule

// ==== source/hazardUnit.sv ====
module hazardUnit import hazardPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  instr_t  instrD,
    output logic    stall,
    output fwdSel_t fwdRsSel,
    output fwdSel_t fwdRtSel
);

    // Decode-stage uses
    regNum_t    rsUse;
    regNum_t    rtUse;
    stageTime_t rsTuse;
    stageTime_t rtTuse;

    // Pending writes in E and M
    instr_t     instrE;
    regNum_t    destE;
    stageTime_t tnewE;
    regNum_t    destM;
    stageTime_t tnewM;

    useDecoder i_useDecoder (
        .instrD (instrD),
        .rsUse  (rsUse),
        .rtUse  (rtUse),
        .rsTuse (rsTuse),
        .rtTuse (rtTuse)
    );

    writeDecoder i_writeDecoder (
        .instrE (instrE),
        .destE  (destE),
        .tnewE  (tnewE)
    );

    stageTracker i_stageTracker (
        .clk    (clk),
        .rstN   (rstN),
        .instrD (instrD),
        .stall  (stall),
        .destE  (destE),
        .tnewE  (tnewE),
        .instrE (instrE),
        .destM  (destM),
        .tnewM  (tnewM)
    );

    stallControl i_stallControl (
        .rsUse    (rsUse),
        .rtUse    (rtUse),
        .rsTuse   (rsTuse),
        .rtTuse   (rtTuse),
        .destE    (destE),
        .tnewE    (tnewE),
        .destM    (destM),
        .tnewM    (tnewM),
        .clk      (clk),
        .stall    (stall),
        .fwdRsSel (fwdRsSel),
        .fwdRtSel (fwdRtSel)
    );

endmodule

// ==== tests/hazardTb.sv ====
`include "hazard_macros.svh"

module hazardTb import hazardPkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clkPeriod   = 8;
    localparam int randomCount = 600;
    localparam int testCycles  = 2000;
    localparam logic [31:0] seedValue = 32'd61;

    // Instruction kinds for the generator
    localparam int kindAdd = 0;
    localparam int kindSub = 1;
    localparam int kindOri = 2;
    localparam int kindLui = 3;
    localparam int kindLw  = 4;
    localparam int kindSw  = 5;
    localparam int kindBeq = 6;
    localparam int kindJ   = 7;
    localparam int kindJal = 8;
    localparam int kindJr  = 9;

    logic    clk;
    logic    rstN;
    instr_t  instrD;
    logic    stall;
    fwdSel_t fwdRsSel;
    fwdSel_t fwdRtSel;

    // Model copy of the E and M write records
    regNum_t    modelDestE;
    stageTime_t modelTnewE;
    regNum_t    modelDestM;
    stageTime_t modelTnewM;

    int          errorCount;
    int          checkCount;
    logic [31:0] lcgState;

    hazardUnit i_hazardUnit (
        .clk      (clk),
        .rstN     (rstN),
        .instrD   (instrD),
        .stall    (stall),
        .fwdRsSel (fwdRsSel),
        .fwdRtSel (fwdRtSel)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // Watchdog sized from the cycle budget of all tests
    initial begin
        #(testCycles * clkPeriod + 200);
        $display("Timeout: the run did not finish within %0d cycles", testCycles);
        $display("Errors found");
        $finish;
    end

    task automatic compareValue(input string what, input logic [31:0] got,
                                input logic [31:0] expected);
        checkCount++;
        if (got !== expected) begin
            errorCount++;
            $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic instr_t buildInstr(input int kind, input regNum_t rs,
                                          input regNum_t rt, input regNum_t rd);
        case (kind)
            kindAdd: return {`OP_ADDSUB_R, rs, rt, rd, 5'd0, `FN_ADD};
            kindSub: return {`OP_ADDSUB_R, rs, rt, rd, 5'd0, `FN_SUB};
            kindOri: return {`OP_ORI, rs, rt, 16'h00ff};
            kindLui: return {`OP_LUI, 5'd0, rt, 16'h1234};
            kindLw:  return {`OP_LW, rs, rt, 16'h0004};
            kindSw:  return {`OP_SW, rs, rt, 16'h0008};
            kindBeq: return {`OP_BEQ, rs, rt, 16'h0002};
            kindJ:   return {`OP_J, 26'h0000010};
            kindJal: return {`OP_JAL, 26'h0000020};
            kindJr:  return {`OP_ADDSUB_R, rs, 15'd0, `FN_JR};
            10:      return `NOP_INSTR;
            11:      return {`OP_ADDSUB_R, rs, rt, rd, 5'd0, 6'b100100};
            default: return {6'b001000, rs, rt, 16'h0010};
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////
    task automatic decodeUses(input instr_t w, output regNum_t rs, output regNum_t rt,
                              output stageTime_t rsT, output stageTime_t rtT);
        logic [5:0] op;
        logic [5:0] fn;
        op  = w[31:26];
        fn  = w[5:0];
        rs  = 5'd0;
        rt  = 5'd0;
        rsT = 2'd0;
        rtT = 2'd0;
        if (op == `OP_ADDSUB_R && (fn == `FN_ADD || fn == `FN_SUB)) begin
            rs  = w[25:21];
            rt  = w[20:16];
            rsT = 2'd1;
            rtT = 2'd1;
        end else if (op == `OP_ADDSUB_R && fn == `FN_JR) begin
            rs = w[25:21];
        end else if (op == `OP_ORI || op == `OP_LW) begin
            rs  = w[25:21];
            rsT = 2'd1;
        end else if (op == `OP_SW) begin
            rs  = w[25:21];
            rt  = w[20:16];
            rsT = 2'd1;
            rtT = 2'd2;
        end else if (op == `OP_BEQ) begin
            rs = w[25:21];
            rt = w[20:16];
        end
    endtask

    task automatic decodeWrite(input instr_t w, output regNum_t dest, output stageTime_t tnew);
        logic [5:0] op;
        logic [5:0] fn;
        op   = w[31:26];
        fn   = w[5:0];
        dest = 5'd0;
        tnew = 2'd0;
        if (op == `OP_LW) begin
            dest = w[20:16];
            tnew = 2'd2;
        end else if (op == `OP_ORI || op == `OP_LUI) begin
            dest = w[20:16];
            tnew = 2'd1;
        end else if (op == `OP_ADDSUB_R && (fn == `FN_ADD || fn == `FN_SUB)) begin
            dest = w[15:11];
            tnew = 2'd1;
        end else if (op == `OP_JAL) begin
            dest = 5'd31;
        end
    endtask

    function automatic logic mustWait(input regNum_t src, input stageTime_t tuse,
                                      input regNum_t dest, input stageTime_t tnew);
        return src != 5'd0 && src == dest && tuse < tnew;
    endfunction

    // E is checked before M
    function automatic fwdSel_t expectedSel(input regNum_t src);
        if (src != 5'd0 && src == modelDestE && modelTnewE == 2'd0) begin
            return `FWD_FROM_E;
        end
        if (src != 5'd0 && src == modelDestM && modelTnewM == 2'd0) begin
            return `FWD_FROM_M;
        end
        return `FWD_NONE;
    endfunction

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    // Present one instruction and hold it until it leaves decode
    task automatic issueInstr(input instr_t w, output int stallCycles,
                              output fwdSel_t rsSel, output fwdSel_t rtSel);
        regNum_t    rs;
        regNum_t    rt;
        stageTime_t rsT;
        stageTime_t rtT;
        logic       expStall;
        logic       entered;
        stallCycles = 0;
        entered     = 1'b0;
        decodeUses(w, rs, rt, rsT, rtT);
        while (!entered) begin
            @(negedge clk);
            instrD = w;
            #(clkPeriod / 2 - 1);
            expStall = mustWait(rs, rsT, modelDestE, modelTnewE)
                     | mustWait(rs, rsT, modelDestM, modelTnewM)
                     | mustWait(rt, rtT, modelDestE, modelTnewE)
                     | mustWait(rt, rtT, modelDestM, modelTnewM);
            compareValue("stall", 32'(stall), 32'(expStall));
            compareValue("fwdRsSel", 32'(fwdRsSel), 32'(expectedSel(rs)));
            compareValue("fwdRtSel", 32'(fwdRtSel), 32'(expectedSel(rt)));
            rsSel   = fwdRsSel;
            rtSel   = fwdRtSel;
            entered = !stall;
            if (stall) begin
                stallCycles++;
            end
            @(posedge clk);
            modelDestM = modelDestE;
            modelTnewM = (modelTnewE == 2'd0) ? 2'd0 : modelTnewE - 2'd1;
            if (expStall) begin
                modelDestE = 5'd0;
                modelTnewE = 2'd0;
            end else begin
                decodeWrite(w, modelDestE, modelTnewE);
            end
        end
    endtask

    // Flush, run three instructions, check how the last one went
    task automatic runSequence(input string name, input instr_t a, input instr_t b,
                               input instr_t c, input int stalls,
                               input fwdSel_t rsExp, input fwdSel_t rtExp);
        int      n;
        fwdSel_t rsSel;
        fwdSel_t rtSel;
        repeat (2) issueInstr(`NOP_INSTR, n, rsSel, rtSel);
        issueInstr(a, n, rsSel, rtSel);
        issueInstr(b, n, rsSel, rtSel);
        issueInstr(c, n, rsSel, rtSel);
        compareValue({name, " stall cycles"}, 32'(n), 32'(stalls));
        compareValue({name, " rs select"}, 32'(rsSel), 32'(rsExp));
        compareValue({name, " rt select"}, 32'(rtSel), 32'(rtExp));
    endtask

    task automatic randomStream();
        int      n;
        int      kind;
        fwdSel_t rsSel;
        fwdSel_t rtSel;
        for (int i = 0; i < randomCount; i++) begin
            lcgState = lcgNext(lcgState);
            kind     = int'(lcgState[31:28]) % 13;
            issueInstr(buildInstr(kind, {2'b00, lcgState[27:25]}, {2'b00, lcgState[24:22]},
                                  {2'b00, lcgState[21:19]}), n, rsSel, rtSel);
        end
    endtask

    initial begin
        errorCount = 0;
        checkCount = 0;
        lcgState   = seedValue;
        rstN       = 1'b0;
        instrD     = `NOP_INSTR;
        modelDestE = 5'd0;
        modelTnewE = 2'd0;
        modelDestM = 5'd0;
        modelTnewM = 2'd0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        runSequence("reset", `NOP_INSTR, `NOP_INSTR, buildInstr(kindBeq, 5'd1, 5'd2, 5'd0),
                    0, `FWD_NONE, `FWD_NONE);
        runSequence("lw-beq", `NOP_INSTR, buildInstr(kindLw, 5'd1, 5'd3, 5'd0),
                    buildInstr(kindBeq, 5'd3, 5'd2, 5'd0), 2, `FWD_NONE, `FWD_NONE);
        runSequence("lw-add", `NOP_INSTR, buildInstr(kindLw, 5'd1, 5'd3, 5'd0),
                    buildInstr(kindAdd, 5'd3, 5'd2, 5'd4), 1, `FWD_NONE, `FWD_NONE);
        runSequence("jal-jr", `NOP_INSTR, buildInstr(kindJal, 5'd0, 5'd0, 5'd0),
                    buildInstr(kindJr, 5'd31, 5'd0, 5'd0), 0, `FWD_FROM_E, `FWD_NONE);
        runSequence("add-nop-add", buildInstr(kindAdd, 5'd1, 5'd2, 5'd5), `NOP_INSTR,
                    buildInstr(kindAdd, 5'd5, 5'd0, 5'd6), 0, `FWD_FROM_M, `FWD_NONE);
        runSequence("jal-jal-jr", buildInstr(kindJal, 5'd0, 5'd0, 5'd0),
                    buildInstr(kindJal, 5'd0, 5'd0, 5'd0),
                    buildInstr(kindJr, 5'd31, 5'd0, 5'd0), 0, `FWD_FROM_E, `FWD_NONE);
        runSequence("lw r0", `NOP_INSTR, buildInstr(kindLw, 5'd1, 5'd0, 5'd0),
                    buildInstr(kindBeq, 5'd0, 5'd0, 5'd0), 0, `FWD_NONE, `FWD_NONE);
        runSequence("add r0", buildInstr(kindAdd, 5'd1, 5'd2, 5'd0), `NOP_INSTR,
                    buildInstr(kindAdd, 5'd0, 5'd0, 5'd7), 0, `FWD_NONE, `FWD_NONE);
        runSequence("lw-sw rt", `NOP_INSTR, buildInstr(kindLw, 5'd1, 5'd3, 5'd0),
                    buildInstr(kindSw, 5'd1, 5'd3, 5'd0), 0, `FWD_NONE, `FWD_NONE);
        runSequence("lw-sw rs", `NOP_INSTR, buildInstr(kindLw, 5'd1, 5'd3, 5'd0),
                    buildInstr(kindSw, 5'd3, 5'd1, 5'd0), 1, `FWD_NONE, `FWD_NONE);
        randomStream();

        $display("Checks run %0d, mismatches %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+source
source/hazardPkg.sv
source/useDecoder.sv
source/writeDecoder.sv
source/stageTracker.sv
source/stallControl.sv
source/hazardUnit.sv
tests/hazardTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the hazard unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f compile.f --top-module hazardTb

simOut=$(./obj_dir/VhazardTb)
echo "$simOut"

if echo "$simOut" | grep -qx "No errors"; then
    exit 0
fi
exit 1
